//--- hw/psx_irq_pkg.sv
package psx_irq_pkg;

   // Eleven request lines, fixed by the hardware map
   localparam int NUM_SRC = 11;

   // Bit position of each source in I_STAT and I_MASK
   typedef enum logic [3:0] {
      IRQ_VBLANK   = 4'd0,
      IRQ_GPU      = 4'd1,
      IRQ_CDROM    = 4'd2,
      IRQ_DMA      = 4'd3,
      IRQ_TIMER0   = 4'd4,
      IRQ_TIMER1   = 4'd5,
      IRQ_TIMER2   = 4'd6,
      IRQ_CTLMEM   = 4'd7,    // Controller and memory card
      IRQ_SIO      = 4'd8,
      IRQ_SPU      = 4'd9,
      IRQ_LIGHTPEN = 4'd10
   } irq_src_e;

   // Byte lane 0 ends at the controller bit, lane 1 holds SIO and up
   localparam int LANE0_TOP = 7;

   // One bit per source, most significant first so it lines up with the register
   typedef struct packed {
      logic lightpen;
      logic spu;
      logic sio;
      logic ctlmem;
      logic timer2;
      logic timer1;
      logic timer0;
      logic dma;
      logic cdrom;
      logic gpu;
      logic vblank;
   } irq_vec_t;

endpackage

//--- hw/psx_bus_pkg.sv
package psx_bus_pkg;

   localparam int DATA_W = 16;
   localparam int BEN_W  = DATA_W / 8;    // One enable per byte lane

   // Register select, decoded from the low address bit by the bus
   typedef enum logic {
      REG_STAT = 1'b0,
      REG_MASK = 1'b1
   } reg_sel_e;

   // Single-cycle CPU access, wen and ren are never high together
   typedef struct packed {
      logic              wen;
      logic              ren;
      logic [BEN_W-1:0]  ben;
      reg_sel_e          sel;
      logic [DATA_W-1:0] wdata;
   } bus_req_t;

endpackage

//--- hw/psx_irq_regs.sv
`timescale 1ns/1ps

module psx_irq_regs (
   input  logic                           sys_clk,
   input  logic                           rst,
   input  psx_bus_pkg::bus_req_t          req_i,
   input  psx_irq_pkg::irq_vec_t          stat_i,
   output psx_irq_pkg::irq_vec_t          mask_o,
   output psx_irq_pkg::irq_vec_t          ack_we_o,
   output psx_irq_pkg::irq_vec_t          ack_data_o,
   output logic [psx_bus_pkg::DATA_W-1:0] rdata_o,
   output logic                           rdata_valid_o
);
   import psx_irq_pkg::*;
   import psx_bus_pkg::*;

   logic [NUM_SRC-1:0] lane_bits;    // Register bits reached by the enabled lanes
   logic [NUM_SRC-1:0] wr_bits;
   logic [NUM_SRC-1:0] stat_wr;
   logic [NUM_SRC-1:0] mask_wr;
   logic [NUM_SRC-1:0] mask_q;
   logic [NUM_SRC-1:0] stat_v;
   logic [DATA_W-1:0]  rd_word;
   logic [DATA_W-1:0]  rdata_q;
   logic               rvalid_q;

   // Spread the byte enables over the register bits
   function automatic logic [NUM_SRC-1:0] lanes_to_bits(input logic [BEN_W-1:0] ben);
      logic [NUM_SRC-1:0] bits;
      bits = '0;
      for (int i = 0; i < NUM_SRC; i++) begin
         if (i <= LANE0_TOP) begin
            bits[i] = ben[0];
         end else begin
            bits[i] = ben[1];
         end
      end
      return bits;
   endfunction

   assign lane_bits = lanes_to_bits(req_i.ben);
   assign wr_bits   = req_i.wdata[NUM_SRC-1:0];
   assign stat_v    = stat_i;

   always_comb begin
      stat_wr = '0;
      mask_wr = '0;
      if (req_i.wen) begin
         if (req_i.sel == REG_STAT) begin
            stat_wr = lane_bits;
         end else begin
            mask_wr = lane_bits;
         end
      end
   end

   // I_STAT is acknowledged in the status block, only the enables are formed here
   assign ack_we_o   = stat_wr;
   assign ack_data_o = wr_bits;

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         mask_q <= '0;
      end else begin
         mask_q <= (mask_q & ~mask_wr) | (wr_bits & mask_wr);
      end
   end

   assign mask_o = mask_q;

   always_comb begin
      case (req_i.sel)
         REG_STAT: rd_word = {{(DATA_W-NUM_SRC){1'b0}}, stat_v};
         default:  rd_word = {{(DATA_W-NUM_SRC){1'b0}}, mask_q};
      endcase
   end

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= req_i.ren;    // One pulse per read strobe
      end
   end

   always_ff @(posedge sys_clk) begin
      if (req_i.ren) begin
         rdata_q <= rd_word;    // Value before this edge's writes
      end
   end

   assign rdata_o       = rdata_q;
   assign rdata_valid_o = rvalid_q;

endmodule

//--- hw/psx_irq_stat.sv
`timescale 1ns/1ps

module psx_irq_stat (
   input  logic                  sys_clk,
   input  logic                  rst,
   input  psx_irq_pkg::irq_vec_t src_i,
   input  psx_irq_pkg::irq_vec_t mask_i,
   input  psx_irq_pkg::irq_vec_t ack_we_i,
   input  psx_irq_pkg::irq_vec_t ack_data_i,
   output psx_irq_pkg::irq_vec_t stat_o,
   output logic                  irq_o
);
   import psx_irq_pkg::*;

   logic [NUM_SRC-1:0] src_v;
   logic [NUM_SRC-1:0] mask_v;
   logic [NUM_SRC-1:0] ack_we_v;
   logic [NUM_SRC-1:0] ack_data_v;
   logic [NUM_SRC-1:0] stat_q;
   logic [NUM_SRC-1:0] stat_d;
   logic [NUM_SRC-1:0] wait_q;    // Set while a captured request is still high
   logic [NUM_SRC-1:0] wait_d;

   assign src_v      = src_i;
   assign mask_v     = mask_i;
   assign ack_we_v   = ack_we_i;
   assign ack_data_v = ack_data_i;

   for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
      logic set_ev;
      logic clr_ev;

      // A request is taken once per high period and only when enabled
      assign set_ev = src_v[i] & ~wait_q[i] & mask_v[i];

      // Writing a zero clears the bit, writing a one leaves it alone
      assign clr_ev = ack_we_v[i] & ~ack_data_v[i];

      always_comb begin
         if (set_ev) begin
            stat_d[i] = 1'b1;    // A new event beats a clear in the same cycle
         end else if (clr_ev) begin
            stat_d[i] = 1'b0;
         end else begin
            stat_d[i] = stat_q[i];
         end
      end

      // The wait flag drops as soon as the line is seen low
      always_comb begin
         if (!src_v[i]) begin
            wait_d[i] = 1'b0;
         end else begin
            wait_d[i] = wait_q[i] | set_ev;
         end
      end
   end

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         stat_q <= '0;
         wait_q <= '0;
      end else begin
         stat_q <= stat_d;
         wait_q <= wait_d;
      end
   end

   assign stat_o = stat_q;

   // Masking a pending bit later hides it from the CPU but keeps it in I_STAT
   assign irq_o = |(stat_q & mask_v);

endmodule

//--- hw/psx_irq_top.sv
`timescale 1ns/1ps

module psx_irq_top (
   input  logic                           sys_clk,
   input  logic                           rst,
   input  psx_bus_pkg::bus_req_t          req_i,
   input  psx_irq_pkg::irq_vec_t          src_i,
   output logic [psx_bus_pkg::DATA_W-1:0] rdata_o,
   output logic                           rdata_valid_o,
   output logic                           irq_o
);
   import psx_irq_pkg::*;

   irq_vec_t mask;
   irq_vec_t ack_we;
   irq_vec_t ack_data;
   irq_vec_t stat;

   // Bus side, holds I_MASK and turns I_STAT writes into acknowledges
   psx_irq_regs i_psx_irq_regs (
      .sys_clk       (sys_clk),
      .rst           (rst),
      .req_i         (req_i),
      .stat_i        (stat),
      .mask_o        (mask),
      .ack_we_o      (ack_we),
      .ack_data_o    (ack_data),
      .rdata_o       (rdata_o),
      .rdata_valid_o (rdata_valid_o)
   );

   // Peripheral side, edge capture and the CPU interrupt line
   psx_irq_stat i_psx_irq_stat (
      .sys_clk    (sys_clk),
      .rst        (rst),
      .src_i      (src_i),
      .mask_i     (mask),
      .ack_we_i   (ack_we),
      .ack_data_i (ack_data),
      .stat_o     (stat),
      .irq_o      (irq_o)
   );

endmodule

//--- tb/psx_irq_assert.sv
`timescale 1ns/1ps

module psx_irq_assert (
   input logic                              sys_clk,
   input logic                              rst,
   input logic [psx_irq_pkg::NUM_SRC-1:0]   src_i,
   input logic [psx_irq_pkg::NUM_SRC-1:0]   stat_i,
   input logic [psx_irq_pkg::NUM_SRC-1:0]   held_i,
   input logic [psx_irq_pkg::NUM_SRC-1:0]   mask_i,
   input logic                              irq_i
);

   // The CPU line stays low in reset and until a status bit was pending or captured
   irq_quiet: assert property (@(posedge sys_clk)
      (rst || !$past((stat_i != '0) || ((src_i & mask_i & ~held_i) != '0)))
      |-> !irq_i)
      else $error("CPU interrupt line high with no status bit pending or captured before");

   // The mask seen at the capturing edge gates every new status bit
   mask_gate: assert property (@(posedge sys_clk) disable iff (rst)
      ((stat_i & ~$past(stat_i) & ~$past(mask_i)) == '0))
      else $error("Status bit rose while its mask bit was clear");

   hold_gate: assert property (@(posedge sys_clk) disable iff (rst)
      ((stat_i & ~$past(stat_i) & $past(held_i)) == '0))
      else $error("Status bit rose again during the same request high period");

endmodule

bind psx_irq_stat psx_irq_assert i_psx_irq_assert (
   .sys_clk (sys_clk),
   .rst     (rst),
   .src_i   (src_v),
   .stat_i  (stat_q),
   .held_i  (wait_q),
   .mask_i  (mask_v),
   .irq_i   (irq_o)
);

//--- tb/psx_irq_checker.sv
`timescale 1ns/1ps

module psx_irq_checker (
   input  logic                           sys_clk,
   input  logic                           rst,
   input  logic [2:0]                     phase_i,
   input  psx_bus_pkg::bus_req_t          req_i,
   input  psx_irq_pkg::irq_vec_t          src_i,
   input  logic [psx_bus_pkg::DATA_W-1:0] rdata_i,
   input  logic                           rdata_valid_i,
   input  logic                           irq_i,
   output int                             val_errs_o,
   output int                             proto_errs_o
);
   import psx_irq_pkg::*;
   import psx_bus_pkg::*;

   typedef struct packed {
      logic [NUM_SRC-1:0] stat;
      logic [NUM_SRC-1:0] held;    // Request already taken in this high period
      logic [NUM_SRC-1:0] mask;
   } model_t;

   model_t            model;
   logic              rd_pend;
   logic [DATA_W-1:0] rd_exp;
   logic              exp_irq;

   function automatic string test_name(input logic [2:0] p);
      case (p)
         3'd0:    return "reset_state";
         3'd1:    return "mask_lanes";
         3'd2:    return "masked_capture";
         3'd3:    return "one_event";
         3'd4:    return "ack_lanes";
         default: return "random_run";
      endcase
   endfunction

   // Next register state after one edge, from the controller rules
   function automatic model_t next_state(input model_t cur, input bus_req_t req,
                                         input logic [NUM_SRC-1:0] src);
      model_t nxt;
      logic   lane_en;
      logic   rise;
      nxt = cur;
      for (int i = 0; i < NUM_SRC; i++) begin
         lane_en = (i <= LANE0_TOP) ? req.ben[0] : req.ben[1];
         rise    = src[i] && !cur.held[i] && cur.mask[i];
         if (rise) begin
            nxt.stat[i] = 1'b1;
         end else if (req.wen && req.sel == REG_STAT && lane_en && !req.wdata[i]) begin
            nxt.stat[i] = 1'b0;
         end
         nxt.held[i] = src[i] && (cur.held[i] || rise);
         if (req.wen && req.sel == REG_MASK && lane_en) begin
            nxt.mask[i] = req.wdata[i];
         end
      end
      return nxt;
   endfunction

   function automatic logic [DATA_W-1:0] read_word(input model_t m, input reg_sel_e sel);
      logic [DATA_W-1:0] word;
      word = '0;
      if (sel == REG_STAT) begin
         word[NUM_SRC-1:0] = m.stat;
      end else begin
         word[NUM_SRC-1:0] = m.mask;
      end
      return word;
   endfunction

   task automatic value_error(input string what, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
      $display("ERROR %s: %s expected 0x%h actual 0x%h at %0t",
               test_name(phase_i), what, exp, act, $time);
      val_errs_o++;
   endtask

   initial begin
      val_errs_o   = 0;
      proto_errs_o = 0;
      rd_pend      = 1'b0;
   end

   // Inputs change just after the rising edge, so the falling edge sees them settled
   always @(negedge sys_clk) begin
      if (rst) begin
         model   = '0;
         rd_pend = 1'b0;
         if (irq_i !== 1'b0) begin
            value_error("irq_o in reset", DATA_W'(1'b0), DATA_W'(irq_i));
         end
      end else begin
         exp_irq = |(model.stat & model.mask);
         if (irq_i !== exp_irq) begin
            value_error("irq_o", DATA_W'(exp_irq), DATA_W'(irq_i));
         end
         if (rdata_valid_i && !rd_pend) begin
            $display("Read data valid pulse at %0t came without a read request", $time);
            proto_errs_o++;
         end else if (rd_pend && !rdata_valid_i) begin
            $display("Read request before %0t got no read data valid pulse", $time);
            proto_errs_o++;
         end else if (rd_pend && rdata_i !== rd_exp) begin
            value_error("rdata_o", rd_exp, rdata_i);
         end
         rd_pend = req_i.ren;
         rd_exp  = read_word(model, req_i.sel);    // Register as it stands before the edge
         model   = next_state(model, req_i, src_i);
      end
   end

endmodule

//--- tb/psx_irq_tb.sv
`timescale 1ns/1ps

module psx_irq_tb;
   import psx_irq_pkg::*;
   import psx_bus_pkg::*;

   localparam int RESET_CYC    = 4;
   localparam int DIRECTED_CYC = 100;    // Directed phases need about 70 cycles
   localparam int RANDOM_CYC   = 600;
   localparam int MARGIN_CYC   = 50;
   localparam int LIMIT_CYC    = RESET_CYC + DIRECTED_CYC + RANDOM_CYC + MARGIN_CYC;

   logic              sys_clk = 1'b0;
   logic              rst;
   bus_req_t          req;
   irq_vec_t          src;
   logic [DATA_W-1:0] rdata;
   logic              rdata_valid;
   logic              irq;
   logic [2:0]        phase;
   int                val_errs;
   int                proto_errs;
   int                cycles = 0;
   logic [31:0]       rng;

   psx_irq_top i_psx_irq_top (
      .sys_clk       (sys_clk),
      .rst           (rst),
      .req_i         (req),
      .src_i         (src),
      .rdata_o       (rdata),
      .rdata_valid_o (rdata_valid),
      .irq_o         (irq)
   );

   psx_irq_checker i_psx_irq_checker (
      .sys_clk       (sys_clk),
      .rst           (rst),
      .phase_i       (phase),
      .req_i         (req),
      .src_i         (src),
      .rdata_i       (rdata),
      .rdata_valid_i (rdata_valid),
      .irq_i         (irq),
      .val_errs_o    (val_errs),
      .proto_errs_o  (proto_errs)
   );

   always #4 sys_clk = ~sys_clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic irq_vec_t one_src(input irq_src_e s);
      logic [NUM_SRC-1:0] v;
      v    = '0;
      v[s] = 1'b1;
      return v;
   endfunction

   task automatic step();
      @(posedge sys_clk);
      #1;
   endtask

   task automatic idle(input int n);
      repeat (n) step();
   endtask

   task automatic bus_write(input reg_sel_e sel, input logic [BEN_W-1:0] ben,
                            input logic [DATA_W-1:0] data);
      req.wen   = 1'b1;
      req.ren   = 1'b0;
      req.sel   = sel;
      req.ben   = ben;
      req.wdata = data;
      step();
      req.wen = 1'b0;
   endtask

   task automatic bus_read(input reg_sel_e sel);
      req.wen = 1'b0;
      req.ren = 1'b1;
      req.sel = sel;
      step();
      req.ren = 1'b0;
      step();    // Read data is fixed at one cycle after the strobe
   endtask

   // One cycle of random source toggles and one random bus access
   task automatic random_cycle();
      logic [31:0] r_op;
      logic [31:0] r_dat;
      rng   = lcg_next(rng);
      r_op  = rng;
      rng   = lcg_next(rng);
      r_dat = rng;
      src   = src ^ (r_op[30:20] & r_dat[14:4]);
      req   = '0;
      case (r_op[3:0])
         4'd0, 4'd1, 4'd2: begin
            req.wen   = 1'b1;
            req.sel   = REG_MASK;
            req.ben   = r_op[5:4];
            req.wdata = r_dat[31:16];
         end
         4'd3, 4'd4, 4'd5, 4'd6: begin
            req.wen   = 1'b1;
            req.sel   = REG_STAT;
            req.ben   = r_op[5:4];
            req.wdata = r_dat[31:16];
         end
         4'd7, 4'd8, 4'd9, 4'd10: begin
            req.ren = 1'b1;
            req.sel = reg_sel_e'(r_op[6]);
         end
         default: begin
         end
      endcase
      step();
   endtask

   initial begin
      rst     = 1'b1;
      req     = '0;
      src     = '0;
      phase   = 3'd0;
      rng     = 32'h72c6_a25a;
      repeat (RESET_CYC) @(posedge sys_clk);
      #1;
      rst = 1'b0;
      step();

      bus_read(REG_STAT);
      bus_read(REG_MASK);
      idle(2);

      phase = 3'd1;
      bus_write(REG_MASK, 2'b01, 16'h07ff);
      bus_read(REG_MASK);
      bus_write(REG_MASK, 2'b10, 16'h0500);
      bus_read(REG_MASK);
      bus_write(REG_MASK, 2'b00, 16'h0000);    // No lane enabled, nothing may change
      bus_read(REG_MASK);
      bus_write(REG_MASK, 2'b11, 16'h0155);
      bus_read(REG_MASK);

      // Mask 0x155 enables vblank, CD-ROM, timer 0, timer 2 and SIO
      phase = 3'd2;
      src = one_src(IRQ_VBLANK);
      step();
      src = '0;
      step();
      bus_read(REG_STAT);
      src = one_src(IRQ_GPU);
      step();
      src = '0;
      step();
      bus_read(REG_STAT);
      bus_write(REG_STAT, 2'b11, 16'h0000);
      bus_read(REG_STAT);

      phase = 3'd3;
      src = one_src(IRQ_CDROM);
      idle(3);
      bus_write(REG_STAT, 2'b01, 16'hfffb);    // Zero only at the CD-ROM bit
      idle(3);
      bus_read(REG_STAT);
      src = '0;
      step();
      src = one_src(IRQ_CDROM);
      step();
      bus_read(REG_STAT);
      src = '0;
      bus_write(REG_STAT, 2'b11, 16'h0000);
      bus_read(REG_STAT);

      phase = 3'd4;
      bus_write(REG_MASK, 2'b11, 16'h07ff);
      src = '1;
      step();
      src = '0;
      step();
      bus_write(REG_STAT, 2'b10, 16'h0000);    // Clears SIO, SPU and lightpen only
      bus_read(REG_STAT);
      bus_write(REG_STAT, 2'b01, 16'h00f0);
      bus_read(REG_STAT);
      src = one_src(IRQ_TIMER0);
      bus_write(REG_STAT, 2'b01, 16'h0000);    // Timer 0 rises in the same cycle as the clear
      bus_read(REG_STAT);
      bus_write(REG_STAT, 2'b11, 16'h0000);
      src = '0;
      bus_read(REG_STAT);

      phase = 3'd5;
      repeat (RANDOM_CYC) random_cycle();
      req = '0;
      src = '0;
      idle(3);

      $display("Error counts: %0d wrong values, %0d protocol errors", val_errs, proto_errs);
      if (val_errs == 0 && proto_errs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   always @(posedge sys_clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT_CYC) begin
         $display("Timeout, stimulus still running after %0d cycles", cycles);
         $display("Something failed");
         $finish;
      end
   end

endmodule

//--- psx_irq_top.f
hw/psx_irq_pkg.sv
hw/psx_bus_pkg.sv
hw/psx_irq_regs.sv
hw/psx_irq_stat.sv
hw/psx_irq_top.sv
tb/psx_irq_assert.sv
tb/psx_irq_checker.sv
tb/psx_irq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the interrupt controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module psx_irq_tb \
   -f psx_irq_top.f -o psx_irq_sim > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/psx_irq_sim > "$LOG" 2>&1 || echo "Simulator returned a failing status"
cat "$LOG"

grep -q "^Everything OK$" "$LOG" && echo "Simulation passed" && exit 0 \
   || { echo "Simulation failed"; exit 1; }
